// ==== project.f ====
+incdir+test
rtl/dispatch_pkg.sv
rtl/port_pkg.sv
rtl/kth_slot_select.sv
rtl/mem_port_merge.sv
rtl/port_rotator.sv
rtl/dispatch_distrib.sv
test/tb_dispatch_distrib.sv

// ==== rtl/dispatch_distrib.sv ====
/* Dispatch distributor. Sends up to nine slots of a decode group to the
   memory, ALU and shift issue ports and reports which slots were granted. */

`timescale 1ns/100ps

module dispatch_distrib (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stall,
  input  dispatch_pkg::class_masks_t classes,
  output port_pkg::port_bundle_t     ports,
  output dispatch_pkg::slot_mask_t   granted
);
  import dispatch_pkg::*;
  import port_pkg::*;

  lane_group_t load_lanes;
  lane_group_t store_lanes;
  lane_group_t alu_lanes;
  lane_group_t shift_lanes;
  lane_count_t store_used;
  lane_count_t shift_used;

  lane_group_t mem_lanes;   // Stores then loads, in logical lane order.
  lane_count_t mem_used;
  lane_group_t mem_rot;
  lane_group_t shift_rot;

  slot_sel_t [NUM_PORTS-1:0] port_sel;  // Flat view of all issue ports.

  //****************************************
  // Per-class slot selection
  //****************************************

  // Load count is implied by the merged memory lanes. ALU lanes never rotate.
  kth_slot_select u_load_sel (
    .mask  (classes.load),
    .lanes (load_lanes),
    .used  ()
  );

  kth_slot_select u_store_sel (
    .mask  (classes.store),
    .lanes (store_lanes),
    .used  (store_used)
  );

  kth_slot_select u_alu_sel (
    .mask  (classes.alu),
    .lanes (alu_lanes),
    .used  ()
  );

  kth_slot_select u_shift_sel (
    .mask  (classes.shift),
    .lanes (shift_lanes),
    .used  (shift_used)
  );

  mem_port_merge u_mem_merge (
    .store_lanes (store_lanes),
    .store_used  (store_used),
    .load_lanes  (load_lanes),
    .lanes       (mem_lanes),
    .used        (mem_used)
  );

  //****************************************
  // Round-robin rotation
  //****************************************

  port_rotator u_mem_rot (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .lanes_in  (mem_lanes),
    .used      (mem_used),
    .lanes_out (mem_rot)
  );

  port_rotator u_shift_rot (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .lanes_in  (shift_lanes),
    .used      (shift_used),
    .lanes_out (shift_rot)
  );

  //****************************************
  // Port bundle and granted mask
  //****************************************

  assign port_sel[MEM_BASE +: LANES]   = mem_rot;
  assign port_sel[ALU_BASE +: LANES]   = alu_lanes;
  assign port_sel[SHIFT_BASE +: LANES] = shift_rot;

  assign ports.mem   = port_sel[MEM_BASE +: LANES];
  assign ports.alu   = port_sel[ALU_BASE +: LANES];
  assign ports.shift = port_sel[SHIFT_BASE +: LANES];

  // Each busy port is one-hot on its slot, so the OR marks every dispatched slot.
  always_comb begin
    granted = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (port_sel[p] != SEL_EMPTY) begin
        granted = granted | port_sel[p];
      end
    end
  end

endmodule

// ==== rtl/dispatch_pkg.sv ====
/* Dispatch decode-group types. Slot masks, slot selects and the per-class
   masks that decode hands to the distributor. */

package dispatch_pkg;

  //****************************************
  // Decode group geometry
  //****************************************

  localparam int NUM_SLOTS = 10;  // Slots in one decode group.

  // One bit per slot, set where the slot holds an op of a given class.
  typedef logic [NUM_SLOTS-1:0] slot_mask_t;

  // A slot select is one-hot on the chosen slot.
  // An idle issue port carries all ones instead.
  typedef logic [NUM_SLOTS-1:0] slot_sel_t;

  localparam slot_sel_t SEL_EMPTY = '1;  // Port has nothing to issue.

  //****************************************
  // Class masks from decode
  //****************************************

  // Decode may mark a slot in at most one class.
  // A slot with no class bit set is not dispatched here.
  typedef struct packed {
    slot_mask_t load;   // Memory reads.
    slot_mask_t store;  // Memory writes, which win the memory lanes first.
    slot_mask_t alu;    // Simple integer ops.
    slot_mask_t shift;  // Shifts and rotates.
  } class_masks_t;

endpackage

// ==== rtl/kth_slot_select.sv ====
/* Picks the first few set slots of a class mask, in slot order, and gives
   each one a lane of its own. */

`timescale 1ns/100ps

module kth_slot_select (
  input  dispatch_pkg::slot_mask_t mask,
  output port_pkg::lane_group_t    lanes,
  output port_pkg::lane_count_t    used
);
  import dispatch_pkg::*;
  import port_pkg::*;

  // Wide enough to count every slot in the group.
  typedef logic [$clog2(NUM_SLOTS + 1)-1:0] slot_cnt_t;

  slot_cnt_t prefix [NUM_SLOTS];  // Set bits in mask[s:0].

  //****************************************
  // Prefix population counts
  //****************************************

  always_comb begin
    prefix[0] = slot_cnt_t'(mask[0]);
    for (int s = 1; s < NUM_SLOTS; s++) begin
      prefix[s] = prefix[s-1] + slot_cnt_t'(mask[s]);
    end
  end

  //****************************************
  // Lane k takes the (k+1)-th set slot
  //****************************************

  // A slot is the k-th set bit when it is set and its prefix count first
  // reaches k+1 there. At most one slot can match, so the select stays one-hot.
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lanes[k] = '0;
      for (int s = 0; s < NUM_SLOTS; s++) begin
        lanes[k][s] = mask[s] && (prefix[s] == slot_cnt_t'(k + 1));
      end
      if (lanes[k] == '0) begin
        lanes[k] = SEL_EMPTY;  // Fewer than k+1 slots in this class.
      end
    end
  end

  // Lanes filled is the popcount, capped at the group size.
  always_comb begin
    if (prefix[NUM_SLOTS-1] < slot_cnt_t'(LANES)) begin
      used = lane_count_t'(prefix[NUM_SLOTS-1]);
    end else begin
      used = lane_count_t'(LANES);
    end
  end

endmodule

// ==== rtl/mem_port_merge.sv ====
/* Memory lane merge. Stores take the leading lanes and loads
   fill whatever is left. */

`timescale 1ns/100ps

module mem_port_merge (
  input  port_pkg::lane_group_t store_lanes,
  input  port_pkg::lane_count_t store_used,
  input  port_pkg::lane_group_t load_lanes,
  output port_pkg::lane_group_t lanes,
  output port_pkg::lane_count_t used
);
  import dispatch_pkg::*;
  import port_pkg::*;

  //****************************************
  // Store before load
  //****************************************

  // Stores sit in lanes 0 to store_used-1. The lanes after them are filled
  // with the loads from load lane 0 upward, so loads also stay in slot order.
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (lane_count_t'(i) < store_used) begin
        lanes[i] = store_lanes[i];
      end else begin
        lanes[i] = load_lanes[i - int'(store_used)];
      end
    end
  end

  // Lanes actually carrying an op. This sets how far the rotation pointer moves.
  always_comb begin
    used = '0;
    for (int i = 0; i < LANES; i++) begin
      if (lanes[i] != SEL_EMPTY) begin
        used = used + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/port_pkg.sv ====
/* Issue port layout. Lane groups, port bases and the round-robin pointer
   used to spread work across a group. */

package port_pkg;

  //****************************************
  // Port map
  //****************************************

  localparam int LANES     = 3;  // Lanes in each port group.
  localparam int NUM_PORTS = 9;

  // First physical port of each group.
  localparam int MEM_BASE   = 0;
  localparam int ALU_BASE   = 3;
  localparam int SHIFT_BASE = 6;

  // Lane i of a group holds the slot select for that lane.
  typedef dispatch_pkg::slot_sel_t [LANES-1:0] lane_group_t;

  typedef logic [1:0] lane_count_t;  // Lanes used, 0 to 3.

  // One-hot rotation offset. Bit r set means lane i lands on port (i + r) mod 3.
  typedef logic [LANES-1:0] rot_ptr_t;

  localparam rot_ptr_t PTR_RESET = rot_ptr_t'(1);

  // Outgoing selects for all nine ports, grouped by unit.
  typedef struct packed {
    lane_group_t mem;    // Ports 0 to 2.
    lane_group_t alu;    // Ports 3 to 5.
    lane_group_t shift;  // Ports 6 to 8.
  } port_bundle_t;

endpackage

// ==== rtl/port_rotator.sv ====
/* Round-robin rotation of one lane group onto its three ports, with
   the pointer advanced by the lanes used each unstalled cycle. */

`timescale 1ns/100ps

module port_rotator (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  port_pkg::lane_group_t lanes_in,
  input  port_pkg::lane_count_t used,
  output port_pkg::lane_group_t lanes_out
);
  import port_pkg::*;

  rot_ptr_t ptr;
  rot_ptr_t ptr_next;

  //****************************************
  // Lane to port mapping
  //****************************************

  // Logical lane i goes out on port (i + r) mod 3 for pointer bit r.
  always_comb begin
    lanes_out = lanes_in;
    for (int r = 0; r < LANES; r++) begin
      if (ptr[r]) begin
        for (int i = 0; i < LANES; i++) begin
          lanes_out[(i + r) % LANES] = lanes_in[i];
        end
      end
    end
  end

  //****************************************
  // Pointer update
  //****************************************

  // Advancing by the lanes used keeps the next op on the port after the last one.
  always_comb begin
    case (used)
      2'd1:    ptr_next = {ptr[LANES-2:0], ptr[LANES-1]};  // r + 1.
      2'd2:    ptr_next = {ptr[0], ptr[LANES-1:1]};        // r + 2.
      default: ptr_next = ptr;  // Zero or a full group leaves r unchanged.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= PTR_RESET;
    end else if (!stall) begin
      ptr <= ptr_next;  // Held while decode replays a stalled group.
    end
  end

endmodule

// ==== test/tb_dispatch_table.svh ====
/* Dispatch table. Each row gives a decode group, the stall input and the
   expected issue ports and granted mask, in the order they are applied. */

// Each row holds the load, store, alu and shift masks with bit s as slot s, then stall,
// the slot on ports 0 to 8 as hex nibbles from the left with F for empty, then granted.
task automatic fill_table();
  // Empty group right after reset.
  add_row(10'b0000000000, 10'b0000000000, 10'b0000000000, 10'b0000000000,
          1'b0, 36'hFFF_FFF_FFF, 10'b0000000000);
  // Five ALU slots. Only the first three reach ports 3 to 5.
  add_row(10'b0000000000, 10'b0000000000, 10'b1001010110, 10'b0000000000,
          1'b0, 36'hFFF_124_FFF, 10'b0000010110);
  // One store ahead of three loads. Slot 7 is left behind.
  add_row(10'b0010100001, 10'b0000001000, 10'b0000000000, 10'b0000000000,
          1'b0, 36'h305_FFF_FFF, 10'b0000101001);
  // Two memory lanes used, so the memory pointer moves to 2.
  add_row(10'b0100000100, 10'b0000000000, 10'b0000000000, 10'b0000000000,
          1'b0, 36'h28F_FFF_FFF, 10'b0100000100);
  // Lane 0 lands on port 2 and lane 1 wraps to port 0.
  add_row(10'b0010000000, 10'b0001000000, 10'b0000000000, 10'b0000000000,
          1'b0, 36'h7F6_FFF_FFF, 10'b0011000000);
  add_row(10'b0000100000, 10'b0000000000, 10'b0000000000, 10'b1000000001,
          1'b0, 36'hF5F_FFF_09F, 10'b1000100001);
  // Same group three times. The first two are stalled, so nothing moves.
  add_row(10'b0000010000, 10'b0000000000, 10'b0000000000, 10'b0000000110,
          1'b1, 36'hFF4_FFF_2F1, 10'b0000010110);
  add_row(10'b0000010000, 10'b0000000000, 10'b0000000000, 10'b0000000110,
          1'b1, 36'hFF4_FFF_2F1, 10'b0000010110);
  add_row(10'b0000010000, 10'b0000000000, 10'b0000000000, 10'b0000000110,
          1'b0, 36'hFF4_FFF_2F1, 10'b0000010110);
  add_row(10'b0000000000, 10'b0000000000, 10'b0010000001, 10'b0100000000,
          1'b0, 36'hFFF_07F_F8F, 10'b0110000001);
  // Four stores fill the memory lanes and the load gets none.
  add_row(10'b1000000000, 10'b0000011110, 10'b0000000000, 10'b0000100000,
          1'b0, 36'h123_FFF_FF5, 10'b0000101110);
  add_row(10'b0000000000, 10'b0000000000, 10'b0000000000, 10'b0000000011,
          1'b0, 36'hFFF_FFF_01F, 10'b0000000011);
endtask

// ==== test/tb_dispatch_distrib.sv ====
/* Testbench for the dispatch distributor. Applies a table of decode groups
   and checks the issue ports and granted mask against expected values. */

`timescale 1ns/100ps

module tb_dispatch_distrib;
  import dispatch_pkg::*;
  import port_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;  // Inputs change this long after a rising edge.
  localparam int RESET_CYCLES = 2;

  typedef struct packed {
    class_masks_t classes;
    logic         stall;
    logic [35:0]  port_slots;  // One nibble per port with port 0 on the left.
    slot_mask_t   granted;
  } row_t;

  logic         clk = 1'b0;
  logic         rst;
  logic         stall;
  class_masks_t classes;
  port_bundle_t ports;
  slot_mask_t   granted;

  row_t rows[$];
  int   cycle_count = 0;
  int   cycle_limit = 0;

  dispatch_distrib u_dispatch_distrib (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .classes (classes),
    .ports   (ports),
    .granted (granted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //****************************************
  // Table building
  //****************************************

  task automatic add_row(input slot_mask_t ld, input slot_mask_t st, input slot_mask_t al,
                         input slot_mask_t sh, input logic stl, input logic [35:0] slots,
                         input slot_mask_t gnt);
    row_t row;
    row.classes.load  = ld;
    row.classes.store = st;
    row.classes.alu   = al;
    row.classes.shift = sh;
    row.stall         = stl;
    row.port_slots    = slots;
    row.granted       = gnt;
    rows.push_back(row);
  endtask

  `include "tb_dispatch_table.svh"

  // Turns the slot numbers of a row into the one-hot selects each port should show.
  function automatic port_bundle_t expect_bundle(input logic [35:0] slots);
    slot_sel_t [NUM_PORTS-1:0] flat;
    logic [3:0]                code;
    port_bundle_t              bundle;
    for (int p = 0; p < NUM_PORTS; p++) begin
      code = slots[35 - 4*p -: 4];
      flat[p] = (code == 4'hF) ? SEL_EMPTY : slot_sel_t'(1) << code;
    end
    bundle.mem   = flat[MEM_BASE +: LANES];
    bundle.alu   = flat[ALU_BASE +: LANES];
    bundle.shift = flat[SHIFT_BASE +: LANES];
    return bundle;
  endfunction

  //****************************************
  // Checks
  //****************************************

  task automatic fail_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped after a failure.");
  endtask

  task automatic check_ports(input port_bundle_t got, input port_bundle_t exp, input int row);
    if (got !== exp) begin
      $display("ERR %0t: row %0d ports mem=%h alu=%h shift=%h", $time, row,
               got.mem, got.alu, got.shift);
      $display("ERR %0t: row %0d expected mem=%h alu=%h shift=%h", $time, row,
               exp.mem, exp.alu, exp.shift);
      fail_run();
    end
  endtask

  task automatic check_granted(input slot_mask_t got, input slot_mask_t exp, input int row);
    if (got !== exp) begin
      $display("ERR %0t: row %0d granted %b, expected %b", $time, row, got, exp);
      fail_run();
    end
  endtask

  // Ends the run if the table stops making progress.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("The run timed out after %0d cycles before the table was done.", cycle_count);
      fail_run();
    end
  end

  //****************************************
  // Stimulus
  //****************************************

  initial begin
    rst     = 1'b1;
    stall   = 1'b0;
    classes = '0;
    fill_table();
    cycle_limit = rows.size() + RESET_CYCLES + 10;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      classes = rows[i].classes;
      stall   = rows[i].stall;
      #(CLK_PERIOD - 2 * DRIVE_DELAY);  // Sample just before the next rising edge.
      check_ports(ports, expect_bundle(rows[i].port_slots), i);
      check_granted(granted, rows[i].granted, i);
      @(posedge clk);
      #DRIVE_DELAY;
    end

    $display("TEST PASS");
    $finish;
  end

endmodule
